//--- logic/dcache_pkg.sv
// Data cache package with geometry, address field positions and the tag entry layout
`default_nettype none

package dcache_pkg;

   // Bus widths
   localparam int ADDR_WIDTH = 32;
   localparam int DATA_WIDTH = 32;
   localparam int SEL_WIDTH  = DATA_WIDTH / 8;

   // Block of 16 bytes, 4 words
   localparam int BLOCK_WIDTH     = 4;
   localparam int WORDS_PER_BLOCK = 2 ** (BLOCK_WIDTH - 2);

   // 64 sets, two ways
   localparam int SET_WIDTH = 6;
   localparam int NUM_WAYS  = 2;

   // Word address inside one way RAM
   localparam int WAY_ADDR_WIDTH = SET_WIDTH + BLOCK_WIDTH - 2;

   // Everything above the index is tag
   localparam int TAG_WIDTH = ADDR_WIDTH - SET_WIDTH - BLOCK_WIDTH;

   // Per way tag and valid, plus one LRU bit per set
   localparam int TAGMEM_WIDTH = NUM_WAYS * (TAG_WIDTH + 1) + 1;

   // Address field positions
   localparam int WORD_LSB     = 2;
   localparam int OFFSET_WIDTH = BLOCK_WIDTH - WORD_LSB;
   localparam int INDEX_LSB    = BLOCK_WIDTH;
   localparam int TAG_LSB      = BLOCK_WIDTH + SET_WIDTH;

   // One tag RAM word
   // The RAM stores the raw vector, the lookup logic decodes the fields
   // lru names the least recently used way of the set
   typedef union packed {
      logic [TAGMEM_WIDTH-1:0] raw;
      struct packed {
         logic                               lru;
         logic [NUM_WAYS-1:0]                valid;
         logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tag;
      } f;
   } tag_entry_t;

endpackage

`default_nettype wire

//--- logic/dcache_sdpram.sv
// Simple dual-port RAM with registered read and write-first bypass
`default_nettype none

module dcache_sdpram #(
   parameter int addr_width = 8,
   parameter int data_width = 32
) (
   input  logic                  clk,
   input  logic [addr_width-1:0] raddr_i,
   input  logic [addr_width-1:0] waddr_i,
   input  logic                  we_i,
   input  logic [data_width-1:0] din_i,
   output logic [data_width-1:0] dout_o
);

   // Storage array
   logic [data_width-1:0] mem [2**addr_width];

   // Write port
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
   end

   // Read port, one edge of latency
   // Same-edge write to the read address shows up on the output
   always_ff @(posedge clk) begin
      if (we_i && (waddr_i == raddr_i)) begin
         dout_o <= din_i;
      end else begin
         dout_o <= mem[raddr_i];
      end
   end

endmodule

`default_nettype wire

//--- logic/dcache_tag_array.sv
// Tag array with per-way hit compare, LRU victim choice and tag entry update
`default_nettype none

module dcache_tag_array import dcache_pkg::*; (
   input  logic                 clk,
   input  logic [SET_WIDTH-1:0] rindex_i,
   input  logic [SET_WIDTH-1:0] windex_i,
   input  logic [TAG_WIDTH-1:0] lookup_tag_i,
   input  logic                 tag_we_i,
   input  logic                 op_fill_i,
   input  logic                 op_touch_i,
   input  logic                 op_clear_i,
   input  logic                 victim_way_i,
   output logic [NUM_WAYS-1:0]  way_hit_o,
   output logic                 hit_o,
   output logic                 victim_o
);

   // Raw RAM words
   logic [TAGMEM_WIDTH-1:0] tag_rdata;
   logic [TAGMEM_WIDTH-1:0] tag_wdata;

   // Decoded views
   tag_entry_t rd_entry;
   tag_entry_t wr_entry;

   // Way that was just accessed, for the LRU update
   logic used_way;

   dcache_sdpram #(
      .addr_width (SET_WIDTH),
      .data_width (TAGMEM_WIDTH)
   ) u_tag_ram (
      .clk     (clk),
      .raddr_i (rindex_i),
      .waddr_i (windex_i),
      .we_i    (tag_we_i),
      .din_i   (tag_wdata),
      .dout_o  (tag_rdata)
   );

   assign rd_entry.raw = tag_rdata;
   assign tag_wdata    = wr_entry.raw;

   // Hit when the way is valid and its tag matches
   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         way_hit_o[w] = rd_entry.f.valid[w] && (rd_entry.f.tag[w] == lookup_tag_i);
      end
   end

   assign hit_o = |way_hit_o;

   // The LRU bit already names the way to replace
   assign victim_o = rd_entry.f.lru;

   // Fill works on the victim, a touch on a hit works on the hitting way
   assign used_way = op_fill_i ? victim_way_i : way_hit_o[1];

   // Build the new entry from the one just read
   always_comb begin
      wr_entry = rd_entry;
      // Fill alone marks the victim invalid, fill with touch makes it valid
      if (op_fill_i) begin
         wr_entry.f.valid[victim_way_i] = op_touch_i;
         wr_entry.f.tag[victim_way_i]   = lookup_tag_i;
      end
      // Point LRU at the other way
      if (op_touch_i) begin
         wr_entry.f.lru = ~used_way;
      end
      // Sweep and invalidate wipe the whole set
      if (op_clear_i) begin
         wr_entry.raw = '0;
      end
   end

endmodule

`default_nettype wire

//--- logic/dcache_data_array.sv
// Two-way data store with byte-select write merge and hit way read mux
`default_nettype none

module dcache_data_array import dcache_pkg::*; (
   input  logic                      clk,
   input  logic [WAY_ADDR_WIDTH-1:0] raddr_i,
   input  logic [WAY_ADDR_WIDTH-1:0] waddr_i,
   input  logic [NUM_WAYS-1:0]       way_we_i,
   input  logic [NUM_WAYS-1:0]       way_hit_i,
   input  logic [DATA_WIDTH-1:0]     wdat_i,
   input  logic [SEL_WIDTH-1:0]      sel_i,
   input  logic                      merge_i,
   output logic [DATA_WIDTH-1:0]     rdat_o
);

   // Per way read words
   logic [DATA_WIDTH-1:0] way_dout [NUM_WAYS];

   // Word written to the ways
   logic [DATA_WIDTH-1:0] merged;
   logic [DATA_WIDTH-1:0] way_din;

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      dcache_sdpram #(
         .addr_width (WAY_ADDR_WIDTH),
         .data_width (DATA_WIDTH)
      ) u_way_ram (
         .clk     (clk),
         .raddr_i (raddr_i),
         .waddr_i (waddr_i),
         .we_i    (way_we_i[w]),
         .din_i   (way_din),
         .dout_o  (way_dout[w])
      );
   end

   // Word of the hitting way
   assign rdat_o = way_hit_i[1] ? way_dout[1] : way_dout[0];

   // CPU bytes where selected, old bytes elsewhere
   always_comb begin
      merged = rdat_o;
      for (int b = 0; b < SEL_WIDTH; b++) begin
         if (sel_i[b]) begin
            merged[8*b +: 8] = wdat_i[8*b +: 8];
         end
      end
   end

   // Refill words go in unchanged
   assign way_din = merge_i ? merged : wdat_i;

endmodule

`default_nettype wire

//--- logic/dcache_ctrl.sv
// Cache controller FSM for sweep, lookup, refill, write-through and invalidate
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
   input  logic                      clk,
   input  logic                      rst,
   // CPU Wishbone slave
   input  logic                      cpu_cyc_i,
   input  logic                      cpu_stb_i,
   input  logic                      cpu_we_i,
   input  logic [ADDR_WIDTH-1:0]     cpu_adr_i,
   input  logic [DATA_WIDTH-1:0]     cpu_dat_i,
   input  logic [SEL_WIDTH-1:0]      cpu_sel_i,
   output logic                      cpu_ack_o,
   // Memory Wishbone master
   output logic                      mem_cyc_o,
   output logic                      mem_stb_o,
   output logic                      mem_we_o,
   output logic [ADDR_WIDTH-1:0]     mem_adr_o,
   output logic [DATA_WIDTH-1:0]     mem_dat_o,
   output logic [SEL_WIDTH-1:0]      mem_sel_o,
   input  logic                      mem_ack_i,
   input  logic [DATA_WIDTH-1:0]     mem_dat_i,
   // Invalidate port
   input  logic                      inv_stb_i,
   input  logic [ADDR_WIDTH-1:0]     inv_adr_i,
   output logic                      inv_ack_o,
   // Tag array
   input  logic                      hit_i,
   input  logic [NUM_WAYS-1:0]       way_hit_i,
   input  logic                      victim_i,
   output logic [SET_WIDTH-1:0]      tag_rindex_o,
   output logic [SET_WIDTH-1:0]      tag_windex_o,
   output logic [TAG_WIDTH-1:0]      lookup_tag_o,
   output logic                      tag_we_o,
   output logic                      op_fill_o,
   output logic                      op_touch_o,
   output logic                      op_clear_o,
   output logic                      victim_way_o,
   // Data array
   output logic [WAY_ADDR_WIDTH-1:0] data_raddr_o,
   output logic [WAY_ADDR_WIDTH-1:0] data_waddr_o,
   output logic [NUM_WAYS-1:0]       way_we_o,
   output logic [DATA_WIDTH-1:0]     way_wdat_o,
   output logic                      merge_o
);

   localparam logic [2:0] SWEEP      = 3'd0;
   localparam logic [2:0] IDLE       = 3'd1;
   localparam logic [2:0] LOOKUP     = 3'd2;
   localparam logic [2:0] REFILL     = 3'd3;
   localparam logic [2:0] WRITE      = 3'd4;
   localparam logic [2:0] INVALIDATE = 3'd5;

   logic [2:0]              state_q;
   logic [SET_WIDTH-1:0]    sweep_cnt_q;
   logic [OFFSET_WIDTH-1:0] refill_cnt_q;
   logic                    victim_q;

   logic                    cpu_req;
   logic [SET_WIDTH-1:0]    cpu_index;
   logic                    refill_first;
   logic                    refill_last;

   assign cpu_req      = cpu_cyc_i & cpu_stb_i;
   assign cpu_index    = cpu_adr_i[TAG_LSB-1:INDEX_LSB];
   assign refill_first = (refill_cnt_q == '0);
   assign refill_last  = (refill_cnt_q == OFFSET_WIDTH'(WORDS_PER_BLOCK - 1));

   // RAMs always read at the CPU address, which is held until ack
   assign tag_rindex_o = cpu_index;
   assign lookup_tag_o = cpu_adr_i[ADDR_WIDTH-1:TAG_LSB];
   assign data_raddr_o = cpu_adr_i[TAG_LSB-1:WORD_LSB];
   assign victim_way_o = victim_q;

   // Write-through carries the CPU word as is
   assign mem_dat_o = cpu_dat_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q      <= SWEEP;
         sweep_cnt_q  <= '0;
         refill_cnt_q <= '0;
         cpu_ack_o    <= 1'b0;
         inv_ack_o    <= 1'b0;
      end else begin
         // Acks last one cycle
         cpu_ack_o <= 1'b0;
         inv_ack_o <= 1'b0;
         case (state_q)
            SWEEP: begin
               sweep_cnt_q <= sweep_cnt_q + 1'b1;
               if (&sweep_cnt_q) begin
                  state_q <= IDLE;
               end
            end
            IDLE: begin
               // Invalidate first, ack cycles do not start a new access
               if (inv_stb_i && !inv_ack_o) begin
                  state_q <= INVALIDATE;
               end else if (cpu_req && !cpu_ack_o) begin
                  state_q <= LOOKUP;
               end
            end
            LOOKUP: begin
               if (cpu_we_i) begin
                  state_q <= WRITE;
               end else if (hit_i) begin
                  cpu_ack_o <= 1'b1;
                  state_q   <= IDLE;
               end else begin
                  refill_cnt_q <= '0;
                  state_q      <= REFILL;
               end
            end
            REFILL: begin
               if (mem_ack_i) begin
                  refill_cnt_q <= refill_cnt_q + 1'b1;
                  // Look up again, which now hits
                  if (refill_last) begin
                     state_q <= LOOKUP;
                  end
               end
            end
            WRITE: begin
               if (mem_ack_i) begin
                  cpu_ack_o <= 1'b1;
                  state_q   <= IDLE;
               end
            end
            INVALIDATE: begin
               inv_ack_o <= 1'b1;
               state_q   <= IDLE;
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   // Victim of the miss, held over the refill
   always_ff @(posedge clk) begin
      if (state_q == LOOKUP) begin
         victim_q <= victim_i;
      end
   end

   always_comb begin
      tag_we_o     = 1'b0;
      op_fill_o    = 1'b0;
      op_touch_o   = 1'b0;
      op_clear_o   = 1'b0;
      tag_windex_o = cpu_index;
      way_we_o     = '0;
      merge_o      = 1'b0;
      data_waddr_o = cpu_adr_i[TAG_LSB-1:WORD_LSB];
      way_wdat_o   = cpu_dat_i;
      mem_cyc_o    = 1'b0;
      mem_stb_o    = 1'b0;
      mem_we_o     = 1'b0;
      // Refill word address by default
      mem_adr_o    = {cpu_adr_i[ADDR_WIDTH-1:BLOCK_WIDTH], refill_cnt_q, {WORD_LSB{1'b0}}};
      mem_sel_o    = '1;
      case (state_q)
         SWEEP: begin
            tag_we_o     = 1'b1;
            op_clear_o   = 1'b1;
            tag_windex_o = sweep_cnt_q;
         end
         LOOKUP: begin
            // Read hit moves LRU
            if (!cpu_we_i && hit_i) begin
               tag_we_o   = 1'b1;
               op_touch_o = 1'b1;
            end
         end
         REFILL: begin
            mem_cyc_o    = 1'b1;
            mem_stb_o    = 1'b1;
            data_waddr_o = {cpu_index, refill_cnt_q};
            way_wdat_o   = mem_dat_i;
            if (mem_ack_i) begin
               way_we_o[victim_q] = 1'b1;
               // Invalid on the first word, valid with new LRU on the last
               if (refill_first || refill_last) begin
                  tag_we_o   = 1'b1;
                  op_fill_o  = 1'b1;
                  op_touch_o = refill_last;
               end
            end
         end
         WRITE: begin
            mem_cyc_o = 1'b1;
            mem_stb_o = 1'b1;
            mem_we_o  = 1'b1;
            mem_adr_o = cpu_adr_i;
            mem_sel_o = cpu_sel_i;
            // Hit way is updated as the memory write completes
            if (mem_ack_i && hit_i) begin
               way_we_o   = way_hit_i;
               merge_o    = 1'b1;
               tag_we_o   = 1'b1;
               op_touch_o = 1'b1;
            end
         end
         INVALIDATE: begin
            tag_we_o     = 1'b1;
            op_clear_o   = 1'b1;
            tag_windex_o = inv_adr_i[TAG_LSB-1:INDEX_LSB];
         end
         default: begin
         end
      endcase
   end

endmodule

`default_nettype wire

//--- logic/dcache_top.sv
// Data cache top level connecting the controller to the tag and data arrays
`default_nettype none

module dcache_top import dcache_pkg::*; (
   input  logic                  clk,
   input  logic                  rst,
   // CPU Wishbone slave
   input  logic                  cpu_cyc_i,
   input  logic                  cpu_stb_i,
   input  logic                  cpu_we_i,
   input  logic [ADDR_WIDTH-1:0] cpu_adr_i,
   input  logic [DATA_WIDTH-1:0] cpu_dat_i,
   input  logic [SEL_WIDTH-1:0]  cpu_sel_i,
   output logic                  cpu_ack_o,
   output logic [DATA_WIDTH-1:0] cpu_dat_o,
   // Memory Wishbone master
   output logic                  mem_cyc_o,
   output logic                  mem_stb_o,
   output logic                  mem_we_o,
   output logic [ADDR_WIDTH-1:0] mem_adr_o,
   output logic [DATA_WIDTH-1:0] mem_dat_o,
   output logic [SEL_WIDTH-1:0]  mem_sel_o,
   input  logic                  mem_ack_i,
   input  logic [DATA_WIDTH-1:0] mem_dat_i,
   // Invalidate port
   input  logic                  inv_stb_i,
   input  logic [ADDR_WIDTH-1:0] inv_adr_i,
   output logic                  inv_ack_o
);

   // Tag array results
   logic                      hit;
   logic [NUM_WAYS-1:0]       way_hit;
   logic                      victim;

   // Tag array controls
   logic [SET_WIDTH-1:0]      tag_rindex;
   logic [SET_WIDTH-1:0]      tag_windex;
   logic [TAG_WIDTH-1:0]      lookup_tag;
   logic                      tag_we;
   logic                      op_fill;
   logic                      op_touch;
   logic                      op_clear;
   logic                      victim_way;

   // Data array controls
   logic [WAY_ADDR_WIDTH-1:0] data_raddr;
   logic [WAY_ADDR_WIDTH-1:0] data_waddr;
   logic [NUM_WAYS-1:0]       way_we;
   logic [DATA_WIDTH-1:0]     way_wdat;
   logic                      merge;

   dcache_ctrl u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .cpu_cyc_i    (cpu_cyc_i),
      .cpu_stb_i    (cpu_stb_i),
      .cpu_we_i     (cpu_we_i),
      .cpu_adr_i    (cpu_adr_i),
      .cpu_dat_i    (cpu_dat_i),
      .cpu_sel_i    (cpu_sel_i),
      .cpu_ack_o    (cpu_ack_o),
      .mem_cyc_o    (mem_cyc_o),
      .mem_stb_o    (mem_stb_o),
      .mem_we_o     (mem_we_o),
      .mem_adr_o    (mem_adr_o),
      .mem_dat_o    (mem_dat_o),
      .mem_sel_o    (mem_sel_o),
      .mem_ack_i    (mem_ack_i),
      .mem_dat_i    (mem_dat_i),
      .inv_stb_i    (inv_stb_i),
      .inv_adr_i    (inv_adr_i),
      .inv_ack_o    (inv_ack_o),
      .hit_i        (hit),
      .way_hit_i    (way_hit),
      .victim_i     (victim),
      .tag_rindex_o (tag_rindex),
      .tag_windex_o (tag_windex),
      .lookup_tag_o (lookup_tag),
      .tag_we_o     (tag_we),
      .op_fill_o    (op_fill),
      .op_touch_o   (op_touch),
      .op_clear_o   (op_clear),
      .victim_way_o (victim_way),
      .data_raddr_o (data_raddr),
      .data_waddr_o (data_waddr),
      .way_we_o     (way_we),
      .way_wdat_o   (way_wdat),
      .merge_o      (merge)
   );

   dcache_tag_array u_tag_array (
      .clk          (clk),
      .rindex_i     (tag_rindex),
      .windex_i     (tag_windex),
      .lookup_tag_i (lookup_tag),
      .tag_we_i     (tag_we),
      .op_fill_i    (op_fill),
      .op_touch_i   (op_touch),
      .op_clear_i   (op_clear),
      .victim_way_i (victim_way),
      .way_hit_o    (way_hit),
      .hit_o        (hit),
      .victim_o     (victim)
   );

   // Read word goes straight to the CPU, valid in the ack cycle
   dcache_data_array u_data_array (
      .clk       (clk),
      .raddr_i   (data_raddr),
      .waddr_i   (data_waddr),
      .way_we_i  (way_we),
      .way_hit_i (way_hit),
      .wdat_i    (way_wdat),
      .sel_i     (cpu_sel_i),
      .merge_i   (merge),
      .rdat_o    (cpu_dat_o)
   );

endmodule

`default_nettype wire

//--- dv/wb_mem_model.sv
// Wishbone slave memory model with one-cycle ack, byte selects and backdoor write
`default_nettype none

module wb_mem_model import dcache_pkg::*; #(
   parameter int mem_words = 4096
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  cyc_i,
   input  logic                  stb_i,
   input  logic                  we_i,
   input  logic [ADDR_WIDTH-1:0] adr_i,
   input  logic [DATA_WIDTH-1:0] dat_i,
   input  logic [SEL_WIDTH-1:0]  sel_i,
   output logic                  ack_o,
   output logic [DATA_WIDTH-1:0] dat_o
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int aw = $clog2(mem_words);

   // Word storage, wraps above the modelled size
   logic [DATA_WIDTH-1:0] mem [mem_words];
   logic [aw-1:0]         word_idx;

   assign word_idx = adr_i[aw+1:2];

   // Ack one cycle after the strobe, then drop for one cycle
   always @(posedge clk) begin
      if (rst) begin
         ack_o <= 1'b0;
         dat_o <= '0;
      end else begin
         ack_o <= cyc_i & stb_i & ~ack_o;
         if (cyc_i && stb_i && !ack_o) begin
            if (we_i) begin
               // Only the selected byte lanes change
               for (int b = 0; b < SEL_WIDTH; b++) begin
                  if (sel_i[b]) begin
                     mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
                  end
               end
            end else begin
               dat_o <= mem[word_idx];
            end
         end
      end
   end

   // Direct store access, bypasses the bus
   task automatic backdoor_write(input int unsigned idx, input logic [DATA_WIDTH-1:0] value);
      mem[idx] = value;
   endtask

endmodule

`default_nettype wire

//--- dv/dcache_tb.sv
// Directed testbench for the two-way write-through data cache
`default_nettype none

module dcache_tb import dcache_pkg::*;;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD   = 40;
   localparam int DRIVE_DELAY  = 5;
   localparam int RESET_CYCLES = 8;
   localparam int MEM_WORDS    = 4096;
   localparam int ACK_TIMEOUT  = 200;
   localparam int RAND_OPS     = 200;
   localparam int NUM_DIRECTED = 5;
   // Sweep plus 200 cycles for each directed test and each random access
   localparam int WATCHDOG_CYCLES =
      RESET_CYCLES + (2 ** SET_WIDTH) + 200 * (NUM_DIRECTED + RAND_OPS);

   logic clk = 1'b0;
   logic rst;

   // CPU side
   logic                  cpu_cyc;
   logic                  cpu_stb;
   logic                  cpu_we;
   logic [ADDR_WIDTH-1:0] cpu_adr;
   logic [DATA_WIDTH-1:0] cpu_wdat;
   logic [SEL_WIDTH-1:0]  cpu_sel;
   logic                  cpu_ack;
   logic [DATA_WIDTH-1:0] cpu_rdat;

   // Memory side
   logic                  mem_cyc;
   logic                  mem_stb;
   logic                  mem_we;
   logic [ADDR_WIDTH-1:0] mem_adr;
   logic [DATA_WIDTH-1:0] mem_wdat;
   logic [SEL_WIDTH-1:0]  mem_sel;
   logic                  mem_ack;
   logic [DATA_WIDTH-1:0] mem_rdat;

   // Invalidate port
   logic                  inv_stb;
   logic [ADDR_WIDTH-1:0] inv_adr;
   logic                  inv_ack;

   // Reference copy of memory that every CPU write updates
   logic [DATA_WIDTH-1:0] ref_mem [MEM_WORDS];

   // Bus monitor results
   int                    rd_count = 0;
   int                    wr_count = 0;
   logic [ADDR_WIDTH-1:0] rd_addr_q[$];
   logic [SEL_WIDTH-1:0]  rd_sel_q[$];
   logic [ADDR_WIDTH-1:0] last_wr_adr;
   logic [DATA_WIDTH-1:0] last_wr_dat;
   logic [SEL_WIDTH-1:0]  last_wr_sel;

   int errors   = 0;
   int n_checks = 0;
   int seed     = 49;

   always #(CLK_PERIOD / 2) clk = ~clk;

   dcache_top dut (
      .clk       (clk),
      .rst       (rst),
      .cpu_cyc_i (cpu_cyc),
      .cpu_stb_i (cpu_stb),
      .cpu_we_i  (cpu_we),
      .cpu_adr_i (cpu_adr),
      .cpu_dat_i (cpu_wdat),
      .cpu_sel_i (cpu_sel),
      .cpu_ack_o (cpu_ack),
      .cpu_dat_o (cpu_rdat),
      .mem_cyc_o (mem_cyc),
      .mem_stb_o (mem_stb),
      .mem_we_o  (mem_we),
      .mem_adr_o (mem_adr),
      .mem_dat_o (mem_wdat),
      .mem_sel_o (mem_sel),
      .mem_ack_i (mem_ack),
      .mem_dat_i (mem_rdat),
      .inv_stb_i (inv_stb),
      .inv_adr_i (inv_adr),
      .inv_ack_o (inv_ack)
   );

   wb_mem_model #(.mem_words(MEM_WORDS)) mem (
      .clk   (clk),
      .rst   (rst),
      .cyc_i (mem_cyc),
      .stb_i (mem_stb),
      .we_i  (mem_we),
      .adr_i (mem_adr),
      .dat_i (mem_wdat),
      .sel_i (mem_sel),
      .ack_o (mem_ack),
      .dat_o (mem_rdat)
   );

   // Count completed memory cycles and remember their details
   always @(posedge clk) begin
      if (mem_cyc && mem_stb && mem_ack) begin
         if (mem_we) begin
            wr_count++;
            last_wr_adr = mem_adr;
            last_wr_dat = mem_wdat;
            last_wr_sel = mem_sel;
         end else begin
            rd_count++;
            rd_addr_q.push_back(mem_adr);
            rd_sel_q.push_back(mem_sel);
         end
      end
   end

   // Odd multiplier keeps every word distinct
   function automatic logic [DATA_WIDTH-1:0] fill_word(input int unsigned idx);
      return (idx * 32'h9e37_79b1) + 32'h1234_5678;
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      n_checks++;
      if (expected !== actual) begin
         errors++;
         $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
      end
   endtask

   // One CPU access that waits for ack with a timeout
   task automatic cpu_access(input logic we, input logic [ADDR_WIDTH-1:0] adr,
                             input logic [DATA_WIDTH-1:0] dat, input logic [SEL_WIDTH-1:0] sel,
                             output logic [DATA_WIDTH-1:0] rdat);
      int cycles;
      cycles = 0;
      rdat   = '0;
      @(posedge clk);
      #DRIVE_DELAY;
      cpu_cyc  = 1'b1;
      cpu_stb  = 1'b1;
      cpu_we   = we;
      cpu_adr  = adr;
      cpu_wdat = dat;
      cpu_sel  = sel;
      do begin
         @(posedge clk);
         #DRIVE_DELAY;
         cycles++;
      end while (!cpu_ack && cycles < ACK_TIMEOUT);
      if (cpu_ack) begin
         rdat = cpu_rdat;
      end else begin
         errors++;
         $display("No ack from the cache for the access at address %h", adr);
      end
      cpu_cyc = 1'b0;
      cpu_stb = 1'b0;
      cpu_we  = 1'b0;
   endtask

   // Read and compare with the reference copy, and optionally check the refill count
   task automatic read_and_check(input logic [ADDR_WIDTH-1:0] adr, input int exp_reads);
      logic [DATA_WIDTH-1:0] rdat;
      int                    rd0;
      int                    wr0;
      rd0 = rd_count;
      wr0 = wr_count;
      cpu_access(1'b0, adr, '0, '1, rdat);
      check("cpu_dat_o", ref_mem[adr[13:2]], rdat);
      check("mem_we_o write count", 0, wr_count - wr0);
      if (exp_reads >= 0) begin
         check("mem read count", exp_reads, rd_count - rd0);
      end
   endtask

   // Write-through makes one memory write and no reads, then the reference follows
   task automatic write_and_check(input logic [ADDR_WIDTH-1:0] adr,
                                  input logic [DATA_WIDTH-1:0] dat,
                                  input logic [SEL_WIDTH-1:0] sel);
      logic [DATA_WIDTH-1:0] unused;
      int                    rd0;
      int                    wr0;
      rd0 = rd_count;
      wr0 = wr_count;
      cpu_access(1'b1, adr, dat, sel, unused);
      check("mem write count", 1, wr_count - wr0);
      check("mem read count", 0, rd_count - rd0);
      check("mem_adr_o", adr, last_wr_adr);
      check("mem_sel_o", sel, last_wr_sel);
      check("mem_dat_o", dat, last_wr_dat);
      for (int b = 0; b < SEL_WIDTH; b++) begin
         if (sel[b]) begin
            ref_mem[adr[13:2]][8*b +: 8] = dat[8*b +: 8];
         end
      end
   endtask

   task automatic invalidate_set(input logic [ADDR_WIDTH-1:0] adr);
      int cycles;
      cycles = 0;
      @(posedge clk);
      #DRIVE_DELAY;
      inv_stb = 1'b1;
      inv_adr = adr;
      do begin
         @(posedge clk);
         #DRIVE_DELAY;
         cycles++;
      end while (!inv_ack && cycles < ACK_TIMEOUT);
      if (!inv_ack) begin
         errors++;
         $display("No invalidate ack from the cache for address %h", adr);
      end
      inv_stb = 1'b0;
   endtask

   // Cold miss refills the aligned block, then every word of it hits
   task automatic miss_then_hit();
      logic [ADDR_WIDTH-1:0] base;
      base = 32'h0000_0120;
      rd_addr_q.delete();
      rd_sel_q.delete();
      read_and_check(base + 4, 4);
      check("refill beats", 4, rd_addr_q.size());
      for (int i = 0; i < WORDS_PER_BLOCK && i < rd_addr_q.size(); i++) begin
         check("refill mem_adr_o", base + 4 * i, rd_addr_q[i]);
         // Refill reads use every byte lane
         check("refill mem_sel_o", {SEL_WIDTH{1'b1}}, rd_sel_q[i]);
      end
      for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
         read_and_check(base + 4 * i, 0);
      end
   endtask

   // Partial write to a cached word merges bytes in cache and memory
   task automatic byte_select_write();
      write_and_check(32'h0000_0128, 32'hdead_beef, 4'b0101);
      read_and_check(32'h0000_0128, 0);
      write_and_check(32'h0000_012c, 32'hcafe_f00d, 4'b1000);
      read_and_check(32'h0000_012c, 0);
   endtask

   // Three tags in one set where the least recently used block goes
   task automatic lru_replacement();
      read_and_check(32'h0000_0200, 4);
      read_and_check(32'h0000_0600, 4);
      read_and_check(32'h0000_0200, 0);
      read_and_check(32'h0000_0a00, 4);
      read_and_check(32'h0000_0200, 0);
      read_and_check(32'h0000_0600, 4);
   endtask

   // Stale data until the set is invalidated
   task automatic stale_until_invalidate();
      logic [ADDR_WIDTH-1:0] adr;
      logic [DATA_WIDTH-1:0] fresh;
      adr = 32'h0000_0304;
      read_and_check(adr, 4);
      fresh = ~ref_mem[adr[13:2]];
      mem.backdoor_write(adr[13:2], fresh);
      // Reference still holds the old word, which the cache returns
      read_and_check(adr, 0);
      ref_mem[adr[13:2]] = fresh;
      invalidate_set(adr);
      read_and_check(adr, 4);
   endtask

   // Write miss goes to memory only
   task automatic write_no_allocate();
      write_and_check(32'h0000_0858, 32'h0bad_c0de, 4'b1111);
      read_and_check(32'h0000_0858, 4);
   endtask

   // Mixed traffic over four tags in two sets
   task automatic random_mix();
      logic [31:0]           r;
      logic [ADDR_WIDTH-1:0] adr;
      logic [DATA_WIDTH-1:0] dat;
      for (int n = 0; n < RAND_OPS; n++) begin
         r   = $random(seed);
         dat = $random(seed);
         adr = (32'(r[1:0]) << TAG_LSB) | (32'(6'h08 + r[2]) << INDEX_LSB) |
               (32'(r[4:3]) << WORD_LSB);
         if (r[5]) begin
            write_and_check(adr, dat, r[9:6]);
         end else begin
            read_and_check(adr, -1);
         end
      end
   endtask

   initial begin
      rst      = 1'b1;
      cpu_cyc  = 1'b0;
      cpu_stb  = 1'b0;
      cpu_we   = 1'b0;
      cpu_adr  = '0;
      cpu_wdat = '0;
      cpu_sel  = '0;
      inv_stb  = 1'b0;
      inv_adr  = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         ref_mem[i] = fill_word(i);
         mem.backdoor_write(i, fill_word(i));
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;
      // The first access simply waits out the tag sweep
      miss_then_hit();
      byte_select_write();
      lru_replacement();
      stale_until_invalidate();
      write_no_allocate();
      random_mix();
      $display("Checks: %0d  Errors: %0d", n_checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // Stops a hung run
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
      $display("Checks: %0d  Errors: %0d", n_checks, errors);
      $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
logic/dcache_pkg.sv
logic/dcache_sdpram.sv
logic/dcache_tag_array.sv
logic/dcache_data_array.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
dv/wb_mem_model.sv
dv/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - logic/dcache_pkg.sv
      - logic/dcache_sdpram.sv
      - logic/dcache_tag_array.sv
      - logic/dcache_data_array.sv
      - logic/dcache_ctrl.sv
      - logic/dcache_top.sv
  - target: test
    files:
      - dv/wb_mem_model.sv
      - dv/dcache_tb.sv
